// ==== verilog/cache_pkg.sv ====
// Fixed geometry of 128 sets, 4 ways, 8 words of 64 bits per line; the 4-way tree PLRU relies on it
`default_nettype none

package cache_pkg;

    // Cache geometry
    localparam int unsigned NUM_SETS   = 128;
    localparam int unsigned NUM_WAYS   = 4;
    localparam int unsigned LINE_WORDS = 8;
    localparam int unsigned TAG_W      = 20;
    localparam int unsigned WORD_W     = 64;

    typedef logic [$clog2(NUM_SETS)-1:0]   set_t;
    typedef logic [TAG_W-1:0]              tag_t;
    typedef logic [NUM_WAYS-1:0]           way_vec_t;
    typedef logic [$clog2(LINE_WORDS)-1:0] word_idx_t;
    typedef logic [WORD_W-1:0]             data_word_t;
    typedef logic [WORD_W/8-1:0]           be_t;

    // One directory entry per set and way
    typedef struct packed {
        logic valid;
        tag_t tag;
    } dir_entry_t;

    typedef struct packed {
        set_t set;
        tag_t tag;
    } dir_lookup_t;

    // Way is one-hot
    typedef struct packed {
        set_t     set;
        way_vec_t way;
        tag_t     tag;
    } dir_refill_t;

    // Any number of ways may be cleared at once
    typedef struct packed {
        set_t     set;
        way_vec_t ways;
    } dir_inval_t;

    // Request read ignores data and be
    typedef struct packed {
        set_t       set;
        word_idx_t  word;
        data_word_t data;
        be_t        be;
    } data_access_t;

    typedef struct packed {
        set_t       set;
        way_vec_t   way;
        word_idx_t  word;
        data_word_t data;
    } data_refill_t;

    // Directory operation of the current cycle
    typedef enum logic [2:0] {
        DIR_IDLE,
        DIR_INIT,
        DIR_LOOKUP,
        DIR_REFILL,
        DIR_INVAL
    } dir_op_e;

    typedef enum logic {
        INIT_CLEAR,
        INIT_DONE
    } init_state_e;

endpackage

`default_nettype wire

// ==== verilog/cache_memctrl_ctrl.sv ====
// Strobes must be at most one-hot per directory and per data group, and stay low until ready_o
`timescale 1ns/1ps
`default_nettype none

module cache_memctrl_ctrl (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    input  wire cache_pkg::dir_lookup_t dir_lookup_i,
    input  wire logic                   dir_lookup_req_i,
    input  wire cache_pkg::dir_refill_t dir_refill_i,
    input  wire logic                   dir_refill_req_i,
    input  wire cache_pkg::dir_inval_t  dir_inval_i,
    input  wire logic                   dir_inval_req_i,
    input  wire logic                   data_read_req_i,
    input  wire logic                   data_write_req_i,
    input  wire logic                   data_refill_req_i,

    output logic                        ready_o,
    output cache_pkg::dir_op_e          dir_op_o,
    output cache_pkg::set_t             dir_addr_o,
    output cache_pkg::way_vec_t         dir_cs_o,
    output cache_pkg::way_vec_t         dir_we_o,
    output cache_pkg::dir_entry_t       dir_wentry_o,
    output cache_pkg::set_t             lookup_set_o,
    output cache_pkg::tag_t             lookup_tag_o
);
    import cache_pkg::*;

    init_state_e state_q;
    set_t        init_set_q;

    // Init walks all sets once after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= INIT_CLEAR;
            init_set_q <= '0;
        end else if (state_q == INIT_CLEAR) begin
            init_set_q <= init_set_q + 1'b1;
            if (init_set_q == set_t'(NUM_SETS - 1)) begin
                state_q <= INIT_DONE;
            end
        end
    end

    assign ready_o = (state_q == INIT_DONE);

    // Fixed priority: init, lookup, refill, invalidate
    always_comb begin
        dir_op_o     = DIR_IDLE;
        dir_addr_o   = '0;
        dir_cs_o     = '0;
        dir_we_o     = '0;
        dir_wentry_o = '0;
        if (state_q == INIT_CLEAR) begin
            dir_op_o   = DIR_INIT;
            dir_addr_o = init_set_q;
            dir_cs_o   = '1;
            dir_we_o   = '1;
        end else if (dir_lookup_req_i) begin
            dir_op_o   = DIR_LOOKUP;
            dir_addr_o = dir_lookup_i.set;
            dir_cs_o   = '1;
        end else if (dir_refill_req_i) begin
            dir_op_o           = DIR_REFILL;
            dir_addr_o         = dir_refill_i.set;
            dir_cs_o           = dir_refill_i.way;
            dir_we_o           = dir_refill_i.way;
            dir_wentry_o.valid = 1'b1;
            dir_wentry_o.tag   = dir_refill_i.tag;
        end else if (dir_inval_req_i) begin
            dir_op_o   = DIR_INVAL;
            dir_addr_o = dir_inval_i.set;
            dir_cs_o   = dir_inval_i.ways;
            dir_we_o   = dir_inval_i.ways;
        end
    end

    // Lookup set and tag for the hit check one cycle later
    always_ff @(posedge clk_i) begin
        if (dir_op_o == DIR_LOOKUP) begin
            lookup_set_o <= dir_lookup_i.set;
            lookup_tag_o <= dir_lookup_i.tag;
        end
    end

    a_dir_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({dir_lookup_req_i, dir_refill_req_i, dir_inval_req_i}))
        else $error("more than one directory request in a cycle");

    a_data_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({data_read_req_i, data_write_req_i, data_refill_req_i}))
        else $error("more than one data request in a cycle");

    // Nothing may arrive during the init sweep
    a_no_req_in_init: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ready_o |-> !(dir_lookup_req_i || dir_refill_req_i || dir_inval_req_i ||
                       data_read_req_i || data_write_req_i || data_refill_req_i))
        else $error("request issued before ready");

endmodule

`default_nettype wire

// ==== verilog/cache_dir_array.sv ====
// Hit way is valid only in the cycle after a lookup; entries are assumed unique per set
`timescale 1ns/1ps
`default_nettype none

module cache_dir_array (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,

    input  wire cache_pkg::dir_op_e    dir_op_i,
    input  wire cache_pkg::set_t       dir_addr_i,
    input  wire cache_pkg::way_vec_t   dir_cs_i,
    input  wire cache_pkg::way_vec_t   dir_we_i,
    input  wire cache_pkg::dir_entry_t dir_wentry_i,
    input  wire cache_pkg::tag_t       lookup_tag_i,

    output cache_pkg::dir_entry_t [cache_pkg::NUM_WAYS-1:0] dir_rentry_o,
    output cache_pkg::way_vec_t        hit_way_o
);
    import cache_pkg::*;

    way_vec_t tag_match;
    logic     lookup_vld_q;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
        dir_entry_t mem_q [NUM_SETS];
        dir_entry_t rentry_q;

        // Read data only changes on a read of this way
        always_ff @(posedge clk_i) begin
            if (dir_cs_i[w]) begin
                if (dir_we_i[w]) begin
                    mem_q[dir_addr_i] <= dir_wentry_i;
                end else begin
                    rentry_q <= mem_q[dir_addr_i];
                end
            end
        end

        assign dir_rentry_o[w] = rentry_q;
        assign tag_match[w]    = rentry_q.valid && (rentry_q.tag == lookup_tag_i);
    end

    // Marks the cycle right after a lookup
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_vld_q <= 1'b0;
        end else begin
            lookup_vld_q <= (dir_op_i == DIR_LOOKUP);
        end
    end

    assign hit_way_o = lookup_vld_q ? tag_match : '0;

    // A tag lives in at most one way of its set
    a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(hit_way_o))
        else $error("tag hits in more than one way");

endmodule

`default_nettype wire

// ==== verilog/cache_victim_sel.sv ====
// Tree PLRU for exactly four ways; a refill wins over a hit update to the same set
`timescale 1ns/1ps
`default_nettype none

module cache_victim_sel (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    input  wire logic                   updt_i,
    input  wire cache_pkg::set_t        updt_set_i,
    input  wire cache_pkg::way_vec_t    updt_way_i,

    input  wire logic                   repl_i,
    input  wire cache_pkg::dir_refill_t repl_req_i,

    input  wire cache_pkg::dir_entry_t [cache_pkg::NUM_WAYS-1:0] dir_rentry_i,
    output cache_pkg::way_vec_t         victim_way_o
);
    import cache_pkg::*;

    // Bit 0 is the root, bit 1 the leaf of ways 0-1, bit 2 the leaf of ways 2-3
    typedef logic [NUM_WAYS-2:0] plru_t;

    plru_t    plru_q [NUM_SETS];
    plru_t    plru;
    way_vec_t valid_vec;

    // Point the path bits away from the touched way
    function automatic plru_t plru_touch(plru_t bits, way_vec_t way);
        plru_t next;
        next = bits;
        if (way[0]) begin
            next[0] = 1'b1;
            next[1] = 1'b1;
        end else if (way[1]) begin
            next[0] = 1'b1;
            next[1] = 1'b0;
        end else if (way[2]) begin
            next[0] = 1'b0;
            next[2] = 1'b1;
        end else if (way[3]) begin
            next[0] = 1'b0;
            next[2] = 1'b0;
        end
        return next;
    endfunction

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                plru_q[s] <= '0;
            end
        end else begin
            if (updt_i && (|updt_way_i)) begin
                plru_q[updt_set_i] <= plru_touch(plru_q[updt_set_i], updt_way_i);
            end
            if (repl_i) begin
                plru_q[repl_req_i.set] <= plru_touch(plru_q[repl_req_i.set], repl_req_i.way);
            end
        end
    end

    // Lowest invalid way first, then the tree
    always_comb begin
        plru         = plru_q[updt_set_i];
        victim_way_o = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            valid_vec[w] = dir_rentry_i[w].valid;
            if (!valid_vec[w]) begin
                victim_way_o = way_vec_t'(1) << w;
            end
        end
        if (&valid_vec) begin
            if (!plru[0]) begin
                victim_way_o = plru[1] ? way_vec_t'(2) : way_vec_t'(1);
            end else begin
                victim_way_o = plru[2] ? way_vec_t'(8) : way_vec_t'(4);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cache_data_array.sv ====
// One 64-bit word per access; a request write must follow its lookup by exactly one cycle
`timescale 1ns/1ps
`default_nettype none

module cache_data_array (
    input  wire logic                    clk_i,

    input  wire cache_pkg::data_access_t data_read_i,
    input  wire logic                    data_read_req_i,
    input  wire cache_pkg::data_access_t data_write_i,
    input  wire logic                    data_write_req_i,
    input  wire cache_pkg::data_refill_t data_refill_i,
    input  wire logic                    data_refill_req_i,
    input  wire cache_pkg::way_vec_t     hit_way_i,

    output cache_pkg::data_word_t        data_read_o
);
    import cache_pkg::*;

    localparam int unsigned DEPTH  = NUM_SETS * LINE_WORDS;
    localparam int unsigned ADDR_W = $clog2(DEPTH);

    typedef logic [ADDR_W-1:0] ram_addr_t;

    ram_addr_t  ram_addr;
    way_vec_t   ram_cs;
    way_vec_t   ram_we;
    be_t        ram_be;
    data_word_t ram_wdata;
    data_word_t ram_rdata [NUM_WAYS];

    function automatic ram_addr_t word_addr(set_t set, word_idx_t word);
        return ram_addr_t'(set) * ram_addr_t'(LINE_WORDS) + ram_addr_t'(word);
    endfunction

    // Only one data request is present per cycle
    always_comb begin
        ram_addr  = word_addr(data_read_i.set, data_read_i.word);
        ram_cs    = '0;
        ram_we    = '0;
        ram_be    = '0;
        ram_wdata = data_write_i.data;
        if (data_refill_req_i) begin
            ram_addr  = word_addr(data_refill_i.set, data_refill_i.word);
            ram_cs    = data_refill_i.way;
            ram_we    = data_refill_i.way;
            ram_be    = '1;
            ram_wdata = data_refill_i.data;
        end else if (data_write_req_i) begin
            // Writes nothing on a miss
            ram_addr = word_addr(data_write_i.set, data_write_i.word);
            ram_cs   = hit_way_i;
            ram_we   = hit_way_i;
            ram_be   = data_write_i.be;
        end else if (data_read_req_i) begin
            ram_cs = '1;
        end
    end

    for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
        data_word_t mem_q [DEPTH];

        always_ff @(posedge clk_i) begin
            if (ram_cs[w]) begin
                if (ram_we[w]) begin
                    for (int b = 0; b < WORD_W / 8; b++) begin
                        if (ram_be[b]) begin
                            mem_q[ram_addr][8*b +: 8] <= ram_wdata[8*b +: 8];
                        end
                    end
                end else begin
                    ram_rdata[w] <= mem_q[ram_addr];
                end
            end
        end
    end

    // Hit way arrives together with the read data
    always_comb begin
        data_read_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            data_read_o |= {WORD_W{hit_way_i[w]}} & ram_rdata[w];
        end
    end

    a_refill_way_onehot: assert property (@(posedge clk_i)
        data_refill_req_i |-> $onehot(data_refill_i.way))
        else $error("data refill way is not one-hot");

endmodule

`default_nettype wire

// ==== verilog/cache_memctrl.sv ====
// No back-pressure; the user must wait for ready_o and keep strobes one-hot per group
`timescale 1ns/1ps
`default_nettype none

module cache_memctrl (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    output logic                         ready_o,

    input  wire cache_pkg::dir_lookup_t  dir_lookup_i,
    input  wire logic                    dir_lookup_req_i,
    input  wire logic                    dir_update_plru_i,
    output cache_pkg::way_vec_t          dir_hit_way_o,
    output cache_pkg::way_vec_t          dir_victim_way_o,

    input  wire cache_pkg::dir_refill_t  dir_refill_i,
    input  wire logic                    dir_refill_req_i,
    input  wire cache_pkg::dir_inval_t   dir_inval_i,
    input  wire logic                    dir_inval_req_i,

    input  wire cache_pkg::data_access_t data_read_i,
    input  wire logic                    data_read_req_i,
    output cache_pkg::data_word_t        data_read_o,
    input  wire cache_pkg::data_access_t data_write_i,
    input  wire logic                    data_write_req_i,
    input  wire cache_pkg::data_refill_t data_refill_i,
    input  wire logic                    data_refill_req_i
);
    import cache_pkg::*;

    dir_op_e                    dir_op;
    set_t                       dir_addr;
    way_vec_t                   dir_cs;
    way_vec_t                   dir_we;
    dir_entry_t                 dir_wentry;
    dir_entry_t [NUM_WAYS-1:0]  dir_rentry;
    set_t                       lookup_set;
    tag_t                       lookup_tag;

    cache_memctrl_ctrl ctrl_i (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .dir_lookup_i      (dir_lookup_i),
        .dir_lookup_req_i  (dir_lookup_req_i),
        .dir_refill_i      (dir_refill_i),
        .dir_refill_req_i  (dir_refill_req_i),
        .dir_inval_i       (dir_inval_i),
        .dir_inval_req_i   (dir_inval_req_i),
        .data_read_req_i   (data_read_req_i),
        .data_write_req_i  (data_write_req_i),
        .data_refill_req_i (data_refill_req_i),
        .ready_o           (ready_o),
        .dir_op_o          (dir_op),
        .dir_addr_o        (dir_addr),
        .dir_cs_o          (dir_cs),
        .dir_we_o          (dir_we),
        .dir_wentry_o      (dir_wentry),
        .lookup_set_o      (lookup_set),
        .lookup_tag_o      (lookup_tag)
    );

    cache_dir_array dir_array_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .dir_op_i     (dir_op),
        .dir_addr_i   (dir_addr),
        .dir_cs_i     (dir_cs),
        .dir_we_i     (dir_we),
        .dir_wentry_i (dir_wentry),
        .lookup_tag_i (lookup_tag),
        .dir_rentry_o (dir_rentry),
        .hit_way_o    (dir_hit_way_o)
    );

    cache_victim_sel victim_sel_i (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .updt_i       (dir_update_plru_i),
        .updt_set_i   (lookup_set),
        .updt_way_i   (dir_hit_way_o),
        .repl_i       (dir_refill_req_i),
        .repl_req_i   (dir_refill_i),
        .dir_rentry_i (dir_rentry),
        .victim_way_o (dir_victim_way_o)
    );

    cache_data_array data_array_i (
        .clk_i             (clk_i),
        .data_read_i       (data_read_i),
        .data_read_req_i   (data_read_req_i),
        .data_write_i      (data_write_i),
        .data_write_req_i  (data_write_req_i),
        .data_refill_i     (data_refill_i),
        .data_refill_req_i (data_refill_req_i),
        .hit_way_i         (dir_hit_way_o),
        .data_read_o       (data_read_o)
    );

endmodule

`default_nettype wire

// ==== sim/tb_cache_memctrl.sv ====
// Directed checks against a reference model; assumes the fixed 4-way, 128-set geometry of cache_pkg
`timescale 1ns/1ps
`default_nettype none

module tb_cache_memctrl;
    import cache_pkg::*;

    localparam int unsigned CLK_PERIOD    = 40;
    localparam int unsigned READY_TIMEOUT = 4 * NUM_SETS;
    localparam set_t        SET_A         = 7'h15;
    localparam set_t        SET_B         = 7'h2a;

    logic         clk;
    logic         rst_n;
    logic         ready;
    dir_lookup_t  dir_lookup;
    logic         dir_lookup_req;
    logic         dir_update_plru;
    way_vec_t     dir_hit_way;
    way_vec_t     dir_victim_way;
    dir_refill_t  dir_refill;
    logic         dir_refill_req;
    dir_inval_t   dir_inval;
    logic         dir_inval_req;
    data_access_t data_read;
    logic         data_read_req;
    data_word_t   data_rdata;
    data_access_t data_write;
    logic         data_write_req;
    data_refill_t data_refill;
    logic         data_refill_req;

    int   error_count;
    int   seed;
    logic ready_ok;
    tag_t tag_a;
    tag_t set_b_tags [NUM_WAYS];

    // Reference model of directory, data and tree bits
    logic       model_valid [NUM_SETS][NUM_WAYS];
    tag_t       model_tag   [NUM_SETS][NUM_WAYS];
    data_word_t model_data  [NUM_WAYS][NUM_SETS*LINE_WORDS];
    logic       plru_root   [NUM_SETS];
    logic       plru_left   [NUM_SETS];
    logic       plru_right  [NUM_SETS];

    cache_memctrl dut_i (
        .clk_i             (clk),
        .rst_ni            (rst_n),
        .ready_o           (ready),
        .dir_lookup_i      (dir_lookup),
        .dir_lookup_req_i  (dir_lookup_req),
        .dir_update_plru_i (dir_update_plru),
        .dir_hit_way_o     (dir_hit_way),
        .dir_victim_way_o  (dir_victim_way),
        .dir_refill_i      (dir_refill),
        .dir_refill_req_i  (dir_refill_req),
        .dir_inval_i       (dir_inval),
        .dir_inval_req_i   (dir_inval_req),
        .data_read_i       (data_read),
        .data_read_req_i   (data_read_req),
        .data_read_o       (data_rdata),
        .data_write_i      (data_write),
        .data_write_req_i  (data_write_req),
        .data_refill_i     (data_refill),
        .data_refill_req_i (data_refill_req)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_way(input string name, input way_vec_t got, input way_vec_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_word(input string name, input data_word_t got, input data_word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic clear_strobes();
        dir_lookup_req  = 1'b0;
        dir_update_plru = 1'b0;
        dir_refill_req  = 1'b0;
        dir_inval_req   = 1'b0;
        data_read_req   = 1'b0;
        data_write_req  = 1'b0;
        data_refill_req = 1'b0;
    endtask

    function automatic int way_index(input way_vec_t way);
        int idx;
        idx = 0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (way[w]) idx = w;
        end
        return idx;
    endfunction

    function automatic int unsigned data_index(input set_t s, input word_idx_t word);
        return int'(s) * LINE_WORDS + int'(word);
    endfunction

    function automatic way_vec_t expected_hit(input set_t s, input tag_t t);
        way_vec_t hit;
        hit = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == t) hit[w] = 1'b1;
        end
        return hit;
    endfunction

    // Lowest invalid way, else walk the tree
    function automatic way_vec_t expected_victim(input set_t s);
        way_vec_t victim;
        logic     found;
        victim = '0;
        found  = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!found && !model_valid[s][w]) begin
                victim = way_vec_t'(1) << w;
                found  = 1'b1;
            end
        end
        if (!found) begin
            if (!plru_root[s]) victim = plru_left[s] ? 4'b0010 : 4'b0001;
            else victim = plru_right[s] ? 4'b1000 : 4'b0100;
        end
        return victim;
    endfunction

    // Path bits point away from the touched way
    task automatic touch_plru(input set_t s, input int w);
        if (w < 2) begin
            plru_root[s] = 1'b1;
            plru_left[s] = (w == 0);
        end else begin
            plru_root[s]  = 1'b0;
            plru_right[s] = (w == 2);
        end
    endtask

    task automatic refill_dir(input set_t s, input int w, input tag_t t);
        dir_refill.set = s;
        dir_refill.way = way_vec_t'(1) << w;
        dir_refill.tag = t;
        dir_refill_req = 1'b1;
        @(negedge clk);
        clear_strobes();
        model_valid[s][w] = 1'b1;
        model_tag[s][w]   = t;
        touch_plru(s, w);
    endtask

    task automatic refill_data(input set_t s, input int w, input word_idx_t word,
                               input data_word_t d);
        data_refill.set  = s;
        data_refill.way  = way_vec_t'(1) << w;
        data_refill.word = word;
        data_refill.data = d;
        data_refill_req  = 1'b1;
        @(negedge clk);
        clear_strobes();
        model_data[w][data_index(s, word)] = d;
    endtask

    task automatic invalidate(input set_t s, input way_vec_t ways);
        dir_inval.set  = s;
        dir_inval.ways = ways;
        dir_inval_req  = 1'b1;
        @(negedge clk);
        clear_strobes();
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ways[w]) model_valid[s][w] = 1'b0;
        end
    endtask

    // Lookup in t, optional read in t, results and optional tree update in t+1
    task automatic lookup_check(input set_t s, input tag_t t, input logic rd,
                                input word_idx_t word, input logic updt);
        way_vec_t   exp_hit;
        data_word_t exp_data;
        dir_lookup.set = s;
        dir_lookup.tag = t;
        dir_lookup_req = 1'b1;
        if (rd) begin
            data_read.set  = s;
            data_read.word = word;
            data_read_req  = 1'b1;
        end
        @(negedge clk);
        clear_strobes();
        exp_hit = expected_hit(s, t);
        check_way("dir_hit_way_o", dir_hit_way, exp_hit);
        check_way("dir_victim_way_o", dir_victim_way, expected_victim(s));
        if (rd) begin
            exp_data = '0;
            if (exp_hit != '0) exp_data = model_data[way_index(exp_hit)][data_index(s, word)];
            check_word("data_read_o", data_rdata, exp_data);
        end
        if (updt) begin
            dir_update_plru = 1'b1;
            @(negedge clk);
            clear_strobes();
            if (exp_hit != '0) touch_plru(s, way_index(exp_hit));
        end
    endtask

    // Write goes one cycle after its lookup into the hit way
    task automatic lookup_write(input set_t s, input tag_t t, input word_idx_t word,
                                input data_word_t d, input be_t be);
        way_vec_t    exp_hit;
        data_word_t  merged;
        int unsigned idx;
        int          w;
        dir_lookup.set = s;
        dir_lookup.tag = t;
        dir_lookup_req = 1'b1;
        @(negedge clk);
        clear_strobes();
        exp_hit = expected_hit(s, t);
        check_way("dir_hit_way_o", dir_hit_way, exp_hit);
        data_write.set  = s;
        data_write.word = word;
        data_write.data = d;
        data_write.be   = be;
        data_write_req  = 1'b1;
        @(negedge clk);
        clear_strobes();
        if (exp_hit != '0) begin
            w      = way_index(exp_hit);
            idx    = data_index(s, word);
            merged = model_data[w][idx];
            for (int b = 0; b < WORD_W / 8; b++) begin
                if (be[b]) merged[8*b +: 8] = d[8*b +: 8];
            end
            model_data[w][idx] = merged;
        end
    endtask

    task automatic wait_ready(output logic ok);
        int cycles;
        check_bit("ready_o", ready, 1'b0);
        check_way("dir_hit_way_o", dir_hit_way, '0);
        cycles = 0;
        while (!ready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        ok = ready;
        if (!ready) begin
            $display("ready_o did not rise within %0d cycles after reset", READY_TIMEOUT);
            error_count++;
        end else if (cycles != NUM_SETS) begin
            $display("ready_o rose after %0d cycles instead of %0d", cycles, NUM_SETS);
            error_count++;
        end
    endtask

    task automatic test_empty_lookups();
        for (int i = 0; i < 8; i++) begin
            lookup_check(set_t'($urandom), tag_t'($urandom), 1'b0, '0, 1'b0);
        end
    endtask

    task automatic test_dir_refill();
        tag_a = tag_t'($urandom);
        refill_dir(SET_A, 2, tag_a);
        lookup_check(SET_A, tag_a, 1'b0, '0, 1'b0);
        // Hit way is still held in the cycle after the lookup
        check_way("dir_hit_way_o", dir_hit_way, 4'b0100);
        lookup_check(SET_A, tag_a ^ tag_t'(1), 1'b0, '0, 1'b0);
    endtask

    task automatic test_data_refill();
        for (int w = 0; w < LINE_WORDS; w++) begin
            refill_data(SET_A, 2, word_idx_t'(w), {$urandom, $urandom});
            lookup_check(SET_A, tag_a, 1'b1, word_idx_t'(w), 1'b0);
        end
        lookup_check(SET_A, tag_a ^ tag_t'(1), 1'b1, word_idx_t'(3), 1'b0);
    endtask

    task automatic test_data_write();
        word_idx_t word;
        for (int i = 0; i < 6; i++) begin
            word = word_idx_t'($urandom);
            lookup_write(SET_A, tag_a, word, {$urandom, $urandom}, be_t'($urandom));
            lookup_check(SET_A, tag_a, 1'b1, word, 1'b0);
        end
        // Miss leaves the line untouched
        lookup_write(SET_A, tag_a ^ tag_t'(1), word_idx_t'(5), {$urandom, $urandom}, '1);
        lookup_check(SET_A, tag_a, 1'b1, word_idx_t'(5), 1'b0);
    endtask

    task automatic test_plru();
        tag_t base;
        tag_t new_tag;
        int   w;
        base = tag_t'($urandom);
        for (int i = 0; i < NUM_WAYS; i++) begin
            set_b_tags[i] = base ^ tag_t'(i);
            lookup_check(SET_B, set_b_tags[i], 1'b0, '0, 1'b0);
            refill_dir(SET_B, way_index(expected_victim(SET_B)), set_b_tags[i]);
        end
        for (int n = 0; n < 16; n++) begin
            if (n % 4 == 3) begin
                new_tag = base ^ tag_t'(16 + n);
                w       = way_index(expected_victim(SET_B));
                lookup_check(SET_B, new_tag, 1'b0, '0, 1'b0);
                set_b_tags[w] = new_tag;
                refill_dir(SET_B, w, new_tag);
            end else begin
                lookup_check(SET_B, set_b_tags[$urandom % NUM_WAYS], 1'b0, '0, 1'b1);
            end
        end
    endtask

    task automatic test_inval();
        way_vec_t ways;
        ways = way_vec_t'($urandom % 14 + 1);
        invalidate(SET_B, ways);
        for (int w = 0; w < NUM_WAYS; w++) begin
            lookup_check(SET_B, set_b_tags[w], 1'b0, '0, 1'b0);
        end
    endtask

    initial begin
        seed = 65102;
        void'($urandom(seed));
        error_count = 0;
        rst_n       = 1'b0;
        dir_lookup  = '0;
        dir_refill  = '0;
        dir_inval   = '0;
        data_read   = '0;
        data_write  = '0;
        data_refill = '0;
        clear_strobes();
        for (int s = 0; s < NUM_SETS; s++) begin
            plru_root[s]  = 1'b0;
            plru_left[s]  = 1'b0;
            plru_right[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        wait_ready(ready_ok);
        if (ready_ok) begin
            test_empty_lookups();
            test_dir_refill();
            test_data_refill();
            test_data_write();
            test_plru();
            test_inval();
        end
        $display("Run finished with %0d error(s)", error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
verilog/cache_pkg.sv
verilog/cache_memctrl_ctrl.sv
verilog/cache_dir_array.sv
verilog/cache_victim_sel.sv
verilog/cache_data_array.sv
verilog/cache_memctrl.sv
sim/tb_cache_memctrl.sv

// ==== Bender.yml ====
package:
  name: cache_memctrl

sources:
  - verilog/cache_pkg.sv
  - verilog/cache_memctrl_ctrl.sv
  - verilog/cache_dir_array.sv
  - verilog/cache_victim_sel.sv
  - verilog/cache_data_array.sv
  - verilog/cache_memctrl.sv
  - target: simulation
    files:
      - sim/tb_cache_memctrl.sv
